// File: verilog/opl_params.svh
`ifndef OPL_PARAMS_SVH
`define OPL_PARAMS_SVH

// number of square-wave voices
`define OPL_NUM_CHANNELS 8

// clocks per sample period
`define OPL_CLK_DIV 256

// phase accumulator and frequency number width
`define OPL_PHASE_WIDTH 16

// one output sample, signed
`define OPL_SAMPLE_WIDTH 16

`endif

// File: verilog/opl_reg_pkg.sv
`default_nettype none

`include "opl_params.svh"

package opl_reg_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [$clog2(`OPL_NUM_CHANNELS)-1:0] chan_idx_t;

    localparam int REGS_PER_CHAN = 4;
    localparam int NUM_REGS = REGS_PER_CHAN * `OPL_NUM_CHANNELS; // 32 bytes

    typedef logic [$clog2(REGS_PER_CHAN)-1:0] reg_field_t; // byte within a channel

    // field offsets, address = 4 * channel + offset
    localparam reg_field_t REG_FNUM_LO = 2'd0;
    localparam reg_field_t REG_FNUM_HI = 2'd1;
    localparam reg_field_t REG_LEVEL   = 2'd2;
    localparam reg_field_t REG_CTRL    = 2'd3;

    // bits of the control byte
    localparam int CTRL_KEY_ON   = 0;
    localparam int CTRL_LEFT_EN  = 1;
    localparam int CTRL_RIGHT_EN = 2;

endpackage

`default_nettype wire

// File: verilog/opl_audio_pkg.sv
`default_nettype none

`include "opl_params.svh"

package opl_audio_pkg;

    typedef logic signed [`OPL_SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [19:0] mix_acc_t;          // headroom for 8 voices
    typedef logic [`OPL_PHASE_WIDTH-1:0] phase_t;

    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    // clamp limits at accumulator width, sign extended
    localparam mix_acc_t MIX_MAX = mix_acc_t'(SAMPLE_MAX);
    localparam mix_acc_t MIX_MIN = mix_acc_t'(SAMPLE_MIN);

    localparam int LEVEL_SHIFT = 6; // level times 64

endpackage

`default_nettype wire

// File: verilog/reg_ram_if.sv
`default_nettype none

interface reg_ram_if;

    logic                   req;
    logic                   we;
    opl_reg_pkg::reg_addr_t addr;
    opl_reg_pkg::reg_data_t wdata;
    logic                   gnt;    // access happens this cycle
    opl_reg_pkg::reg_data_t rdata;
    logic                   rvalid; // one cycle after a read grant

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

`default_nettype wire

// File: verilog/sample_clk_div.sv
`default_nettype none

`include "opl_params.svh"

module sample_clk_div (
    input  logic clk,
    input  logic reset,
    output logic sample_clk_en
);

    localparam int CNT_W = $clog2(`OPL_CLK_DIV);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count         <= '0;
            sample_clk_en <= 1'b0;
        end else begin
            if (count == CNT_W'(`OPL_CLK_DIV - 1)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            sample_clk_en <= (count == CNT_W'(`OPL_CLK_DIV - 1)); // pulse on wrap
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_ram_arbiter.sv
`default_nettype none

module reg_ram_arbiter (
    input  logic       clk,
    input  logic       reset,
    reg_ram_if.arbiter host_bus,
    reg_ram_if.arbiter voice_bus
);

    localparam int IDX_W = $clog2(opl_reg_pkg::NUM_REGS);

    opl_reg_pkg::reg_data_t mem [opl_reg_pkg::NUM_REGS];

    logic                   prefer_host; // winner of the next collision
    logic                   host_gnt;
    logic                   voice_gnt;
    logic                   acc_we;
    opl_reg_pkg::reg_addr_t acc_addr;
    opl_reg_pkg::reg_data_t acc_wdata;
    logic                   acc_in_range;
    logic [IDX_W-1:0]       acc_idx;
    opl_reg_pkg::reg_data_t rd_data;
    logic                   host_rvalid;
    logic                   voice_rvalid;

    always_comb begin
        host_gnt     = host_bus.req && (!voice_bus.req || prefer_host);
        voice_gnt    = voice_bus.req && !host_gnt;
        acc_we       = host_gnt ? host_bus.we : voice_bus.we;
        acc_addr     = host_gnt ? host_bus.addr : voice_bus.addr;
        acc_wdata    = host_gnt ? host_bus.wdata : voice_bus.wdata;
        acc_in_range = (acc_addr < opl_reg_pkg::NUM_REGS);
        acc_idx      = acc_addr[IDX_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < opl_reg_pkg::NUM_REGS; i++) begin
                mem[i] <= '0;
            end
            prefer_host  <= 1'b1;
            host_rvalid  <= 1'b0;
            voice_rvalid <= 1'b0;
        end else begin
            if (host_bus.req && voice_bus.req) begin
                prefer_host <= !prefer_host; // alternate only on collision
            end
            if ((host_gnt || voice_gnt) && acc_we && acc_in_range) begin
                mem[acc_idx] <= acc_wdata; // out of range writes dropped
            end
            host_rvalid  <= host_gnt && !host_bus.we;
            voice_rvalid <= voice_gnt && !voice_bus.we;
        end
    end

    // one read port shared by both peers
    always_ff @(posedge clk) begin
        if ((host_gnt || voice_gnt) && !acc_we) begin
            rd_data <= acc_in_range ? mem[acc_idx] : '0;
        end
    end

    assign host_bus.gnt     = host_gnt;
    assign host_bus.rdata   = rd_data;
    assign host_bus.rvalid  = host_rvalid;
    assign voice_bus.gnt    = voice_gnt;
    assign voice_bus.rdata  = rd_data;
    assign voice_bus.rvalid = voice_rvalid;

endmodule

`default_nettype wire

// File: verilog/host_reg_port.sv
`default_nettype none

module host_reg_port (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cs,
    input  logic                   rd,
    input  logic                   wr,
    input  opl_reg_pkg::reg_addr_t address,
    input  opl_reg_pkg::reg_data_t data_in,
    output opl_reg_pkg::reg_data_t data_out,
    output logic                   rd_valid,
    output logic                   busy,
    reg_ram_if.requester           host_bus
);

    logic                   pending;  // access waiting for its grant
    logic                   req_we;
    opl_reg_pkg::reg_addr_t req_addr;
    opl_reg_pkg::reg_data_t req_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            req_we  <= 1'b0;
        end else if (!pending) begin
            if (cs && (rd || wr)) begin
                pending <= 1'b1;
                req_we  <= wr; // write wins if both strobes
            end
        end else if (host_bus.gnt) begin
            pending <= 1'b0;
        end
    end

    // captured with the strobe, held until the grant
    always_ff @(posedge clk) begin
        if (!pending && cs && (rd || wr)) begin
            req_addr  <= address;
            req_wdata <= data_in;
        end
    end

    assign host_bus.req   = pending;
    assign host_bus.we    = req_we;
    assign host_bus.addr  = req_addr;
    assign host_bus.wdata = req_wdata;

    assign busy     = pending;
    assign rd_valid = host_bus.rvalid;
    assign data_out = host_bus.rdata;

endmodule

`default_nettype wire

// File: verilog/voice_sequencer.sv
`default_nettype none

`include "opl_params.svh"

module voice_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample_clk_en,
    reg_ram_if.requester            voice_bus,
    output opl_audio_pkg::sample_t  sample_l,
    output opl_audio_pkg::sample_t  sample_r,
    output logic                    sample_strobe
);

    localparam opl_reg_pkg::chan_idx_t LAST_CHAN =
        opl_reg_pkg::chan_idx_t'(`OPL_NUM_CHANNELS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,   // request held until gnt
        S_WAIT,   // byte returns with rvalid
        S_VOICE,
        S_CLAMP
    } seq_state_t;

    seq_state_t                  state;
    opl_reg_pkg::chan_idx_t      chan;
    opl_reg_pkg::reg_field_t     field;
    opl_audio_pkg::phase_t       fnum;
    opl_reg_pkg::reg_data_t      level;
    opl_reg_pkg::reg_data_t      ctrl;
    opl_audio_pkg::phase_t       phase [`OPL_NUM_CHANNELS];
    opl_audio_pkg::phase_t       cur_phase;
    opl_audio_pkg::mix_acc_t     magnitude;
    opl_audio_pkg::mix_acc_t     voice_val;
    opl_audio_pkg::mix_acc_t     acc_l;
    opl_audio_pkg::mix_acc_t     acc_r;

    function automatic opl_audio_pkg::sample_t clamp_sample(input opl_audio_pkg::mix_acc_t sum);
        if (sum > opl_audio_pkg::MIX_MAX) begin
            return opl_audio_pkg::SAMPLE_MAX;
        end else if (sum < opl_audio_pkg::MIX_MIN) begin
            return opl_audio_pkg::SAMPLE_MIN;
        end
        return opl_audio_pkg::sample_t'(sum);
    endfunction

    // square wave, sign from the phase MSB
    always_comb begin
        cur_phase = phase[chan];
        magnitude = opl_audio_pkg::mix_acc_t'(level) <<< opl_audio_pkg::LEVEL_SHIFT;
        if (!ctrl[opl_reg_pkg::CTRL_KEY_ON]) begin
            voice_val = '0;
        end else if (cur_phase[`OPL_PHASE_WIDTH-1]) begin
            voice_val = -magnitude;
        end else begin
            voice_val = magnitude;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= S_IDLE;
            chan          <= '0;
            field         <= opl_reg_pkg::REG_FNUM_LO;
            sample_strobe <= 1'b0;
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
                phase[i] <= '0;
            end
        end else begin
            sample_strobe <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (sample_clk_en) begin
                        chan  <= '0;
                        field <= opl_reg_pkg::REG_FNUM_LO;
                        acc_l <= '0;
                        acc_r <= '0;
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    if (voice_bus.gnt) state <= S_WAIT;
                end
                S_WAIT: begin
                    if (voice_bus.rvalid) begin
                        case (field)
                            opl_reg_pkg::REG_FNUM_LO: fnum[7:0]  <= voice_bus.rdata;
                            opl_reg_pkg::REG_FNUM_HI: fnum[15:8] <= voice_bus.rdata;
                            opl_reg_pkg::REG_LEVEL:   level      <= voice_bus.rdata;
                            opl_reg_pkg::REG_CTRL:    ctrl       <= voice_bus.rdata;
                            default: ;
                        endcase
                        if (field == opl_reg_pkg::REG_CTRL) begin
                            state <= S_VOICE;
                        end else begin
                            field <= field + 1'b1;
                            state <= S_READ;
                        end
                    end
                end
                S_VOICE: begin
                    if (ctrl[opl_reg_pkg::CTRL_LEFT_EN]) acc_l <= acc_l + voice_val;
                    if (ctrl[opl_reg_pkg::CTRL_RIGHT_EN]) acc_r <= acc_r + voice_val;
                    // phase advances after use, cleared on key-off
                    if (ctrl[opl_reg_pkg::CTRL_KEY_ON]) begin
                        phase[chan] <= cur_phase + fnum;
                    end else begin
                        phase[chan] <= '0;
                    end
                    if (chan == LAST_CHAN) begin
                        state <= S_CLAMP;
                    end else begin
                        chan  <= chan + 1'b1;
                        field <= opl_reg_pkg::REG_FNUM_LO;
                        state <= S_READ;
                    end
                end
                S_CLAMP: begin
                    sample_l      <= clamp_sample(acc_l);
                    sample_r      <= clamp_sample(acc_r);
                    sample_strobe <= 1'b1;
                    state         <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // {chan, field} is 4 * chan + field
    assign voice_bus.req   = (state == S_READ);
    assign voice_bus.we    = 1'b0;           // read only peer
    assign voice_bus.addr  = opl_reg_pkg::reg_addr_t'({chan, field});
    assign voice_bus.wdata = '0;

endmodule

`default_nettype wire

// File: verilog/serial_audio_tx.sv
`default_nettype none

`include "opl_params.svh"

module serial_audio_tx (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sample_strobe,
    input  opl_audio_pkg::sample_t sample_l,
    input  opl_audio_pkg::sample_t sample_r,
    output logic                   i2s_sclk,
    output logic                   i2s_ws,
    output logic                   i2s_sd
);

    localparam int FRAME_BITS = 2 * `OPL_SAMPLE_WIDTH;
    localparam int BIT_W = $clog2(FRAME_BITS);

    logic                  active;
    logic [1:0]            div;     // sclk is clk / 4
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shift;   // left word in the upper half

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            div      <= '0;
            bit_cnt  <= '0;
            shift    <= '0;
            i2s_sclk <= 1'b0;
            i2s_ws   <= 1'b1;
        end else if (!active) begin
            if (sample_strobe) begin
                active  <= 1'b1;
                div     <= '0;
                bit_cnt <= '0;
                shift   <= {sample_l, sample_r};
                i2s_ws  <= 1'b0; // left MSB goes out with ws
            end
        end else begin
            div <= div + 1'b1;
            if (div == 2'd1) begin
                i2s_sclk <= 1'b1;
            end
            if (div == 2'd3) begin
                // falling edge of sclk, next bit out
                i2s_sclk <= 1'b0;
                shift    <= {shift[FRAME_BITS-2:0], 1'b0};
                bit_cnt  <= bit_cnt + 1'b1;
                i2s_ws   <= (bit_cnt >= BIT_W'(`OPL_SAMPLE_WIDTH - 1));
                if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                    active <= 1'b0; // ws stays high, sd empties to 0
                end
            end
        end
    end

    assign i2s_sd = shift[FRAME_BITS-1];

endmodule

`default_nettype wire

// File: verilog/opl_top.sv
`default_nettype none

module opl_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       cs,
    input  logic       rd,
    input  logic       wr,
    input  logic [7:0] address,
    input  logic [7:0] data_in,
    output logic [7:0] data_out,
    output logic       rd_valid,
    output logic       busy,
    output logic       i2s_sclk,
    output logic       i2s_ws,
    output logic       i2s_sd
);

    logic                   sample_clk_en;
    logic                   sample_strobe;
    opl_audio_pkg::sample_t sample_l;
    opl_audio_pkg::sample_t sample_r;

    reg_ram_if host_bus ();
    reg_ram_if voice_bus ();

    sample_clk_div i_clk_div (
        .clk           (clk),
        .reset         (reset),
        .sample_clk_en (sample_clk_en)
    );

    reg_ram_arbiter i_arbiter (
        .clk       (clk),
        .reset     (reset),
        .host_bus  (host_bus),
        .voice_bus (voice_bus)
    );

    host_reg_port i_host_port (
        .clk      (clk),
        .reset    (reset),
        .cs       (cs),
        .rd       (rd),
        .wr       (wr),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .rd_valid (rd_valid),
        .busy     (busy),
        .host_bus (host_bus)
    );

    voice_sequencer i_sequencer (
        .clk           (clk),
        .reset         (reset),
        .sample_clk_en (sample_clk_en),
        .voice_bus     (voice_bus),
        .sample_l      (sample_l),
        .sample_r      (sample_r),
        .sample_strobe (sample_strobe)
    );

    serial_audio_tx i_serial_tx (
        .clk           (clk),
        .reset         (reset),
        .sample_strobe (sample_strobe),
        .sample_l      (sample_l),
        .sample_r      (sample_r),
        .i2s_sclk      (i2s_sclk),
        .i2s_ws        (i2s_ws),
        .i2s_sd        (i2s_sd)
    );

endmodule

`default_nettype wire

// File: verif/opl_tb.sv
`default_nettype none

`include "opl_params.svh"

module opl_tb;

    logic        clk;
    logic        reset;
    logic        cs;
    logic        rd;
    logic        wr;
    logic [7:0]  address;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic        rd_valid;
    logic        busy;
    logic        i2s_sclk;
    logic        i2s_ws;
    logic        i2s_sd;

    logic [7:0]  regs [32];                   // register model
    logic [7:0]  stage [32];                  // next register image to load
    logic [15:0] phases [`OPL_NUM_CHANNELS];  // phase model
    logic [15:0] left_q [$];
    logic [15:0] right_q [$];
    logic [31:0] frame_bits;
    int          bit_idx;
    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    logic        playback_done;

    opl_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .cs       (cs),
        .rd       (rd),
        .wr       (wr),
        .address  (address),
        .data_in  (data_in),
        .data_out (data_out),
        .rd_valid (rd_valid),
        .busy     (busy),
        .i2s_sclk (i2s_sclk),
        .i2s_ws   (i2s_ws),
        .i2s_sd   (i2s_sd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // serial decoder, one bit per sclk rise
    always @(posedge i2s_sclk) begin
        check_value("i2s_ws", 32'(i2s_ws), (bit_idx >= 16) ? 32'd1 : 32'd0);
        frame_bits = {frame_bits[30:0], i2s_sd};
        if (bit_idx == 31) begin
            left_q.push_back(frame_bits[31:16]);
            right_q.push_back(frame_bits[15:0]);
            bit_idx = 0;
        end else begin
            bit_idx++;
        end
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    function automatic logic [15:0] clamp_sum(input int sum);
        if (sum > 32767) return 16'h7fff;
        if (sum < -32768) return 16'h8000;
        return 16'(sum);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic drain_busy();
        int waited;
        waited = 0;
        while (busy && waited < 100) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (busy) begin
            $display("timeout: busy stayed high after a host access");
            errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        #10;
        cs = 1'b1;
        wr = 1'b1;
        address = addr;
        data_in = data;
        @(posedge clk);
        #10;
        cs = 1'b0;
        wr = 1'b0;
        drain_busy();
        if (addr < 8'd32) regs[addr[4:0]] = data;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
        int waited;
        @(posedge clk);
        #10;
        cs = 1'b1;
        rd = 1'b1;
        address = addr;
        @(posedge clk);
        #10;
        cs = 1'b0;
        rd = 1'b0;
        waited = 0;
        data = 8'h00;
        while (!rd_valid && waited < 100) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (rd_valid) begin
            data = data_out;
            check_value("busy", 32'(busy), 32'd0);
        end else begin
            $display("timeout: no rd_valid for a read of address 0x%0h", addr);
            errors++;
        end
    endtask

    // next fall of ws, the start of a new frame
    task automatic sync_to_frame();
        int waited;
        waited = 0;
        while (!i2s_ws && waited < 4 * `OPL_CLK_DIV) begin
            @(posedge clk);
            #10;
            waited++;
        end
        while (i2s_ws && waited < 4 * `OPL_CLK_DIV) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (waited >= 4 * `OPL_CLK_DIV) begin
            $display("timeout: no serial frame started");
            errors++;
        end
    endtask

    task automatic get_frame(output logic [15:0] l, output logic [15:0] r);
        int waited;
        waited = 0;
        l = 16'h0;
        r = 16'h0;
        while (left_q.size() == 0 && waited < 4 * `OPL_CLK_DIV) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (left_q.size() == 0) begin
            $display("timeout: no complete serial frame decoded");
            errors++;
        end else begin
            l = left_q.pop_front();
            r = right_q.pop_front();
        end
    endtask

    // one scan of the square-wave rule, then phase advance
    task automatic model_step(output logic [15:0] exp_l, output logic [15:0] exp_r);
        int          sum_l;
        int          sum_r;
        int          voice;
        int          lvl;
        int          ch;
        logic [7:0]  ctrl;
        logic [15:0] fnum;
        sum_l = 0;
        sum_r = 0;
        for (ch = 0; ch < `OPL_NUM_CHANNELS; ch++) begin
            fnum  = {regs[4*ch+1], regs[4*ch]};
            lvl   = int'(regs[4*ch+2]) * 64;
            ctrl  = regs[4*ch+3];
            voice = 0;
            if (ctrl[0]) voice = phases[ch][15] ? -lvl : lvl;
            if (ctrl[1]) sum_l += voice;
            if (ctrl[2]) sum_r += voice;
            phases[ch] = ctrl[0] ? phases[ch] + fnum : 16'h0;
        end
        exp_l = clamp_sum(sum_l);
        exp_r = clamp_sum(sum_r);
    endtask

    task automatic expect_frames(input int count);
        logic [15:0] l;
        logic [15:0] r;
        logic [15:0] exp_l;
        logic [15:0] exp_r;
        repeat (count) begin
            get_frame(l, r);
            model_step(exp_l, exp_r);
            check_value("left word", 32'(l), 32'(exp_l));
            check_value("right word", 32'(r), 32'(exp_r));
        end
    endtask

    // silence all voices, then load the staged image between two scans
    task automatic load_regs();
        logic [15:0] l;
        logic [15:0] r;
        int          ch;
        int          a;
        sync_to_frame();
        for (ch = 0; ch < `OPL_NUM_CHANNELS; ch++) write_reg(8'(4 * ch + 3), 8'h00);
        sync_to_frame();
        left_q.delete();
        right_q.delete();
        for (a = 0; a < 32; a++) write_reg(8'(a), stage[a]);
        for (ch = 0; ch < `OPL_NUM_CHANNELS; ch++) phases[ch] = 16'h0;
        get_frame(l, r); // silent scan, still in flight during the writes
    endtask

    task automatic random_voices();
        logic [31:0] rnd;
        int          ch;
        for (ch = 0; ch < `OPL_NUM_CHANNELS; ch++) begin
            rnd = next_random();
            stage[4*ch]   = rnd[7:0];
            stage[4*ch+1] = rnd[15:8];
            stage[4*ch+2] = rnd[23:16];
            stage[4*ch+3] = {5'b0, rnd[26:25], rnd[24] | (ch < 3)};
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic verify_reset_state();
        logic [7:0]  d;
        logic [15:0] l;
        logic [15:0] r;
        int          a;
        // idle outputs right after reset
        check_value("busy", 32'(busy), 32'd0);
        check_value("rd_valid", 32'(rd_valid), 32'd0);
        check_value("i2s_sclk", 32'(i2s_sclk), 32'd0);
        check_value("i2s_ws", 32'(i2s_ws), 32'd1);
        check_value("i2s_sd", 32'(i2s_sd), 32'd0);
        for (a = 0; a < 32; a++) begin
            read_reg(8'(a), d);
            check_value("data_out", 32'(d), 32'd0);
        end
        get_frame(l, r);
        check_value("left word", 32'(l), 32'd0);
        check_value("right word", 32'(r), 32'd0);
        end_test("reset state");
    endtask

    task automatic register_access();
        logic [31:0] rnd;
        logic [7:0]  d;
        int          a;
        for (a = 0; a < 32; a++) begin
            rnd = next_random();
            write_reg(8'(a), rnd[7:0]);
        end
        for (a = 0; a < 32; a++) begin
            read_reg(8'(a), d);
            check_value("data_out", 32'(d), 32'(regs[a]));
        end
        write_reg(8'd45, 8'h5a); // no register there
        read_reg(8'd45, d);
        check_value("data_out", 32'(d), 32'd0);
        @(posedge clk);
        #10;
        cs = 1'b1;
        wr = 1'b1;
        address = 8'd6;
        data_in = 8'h3c;
        @(posedge clk);
        #10;
        check_value("busy", 32'(busy), 32'd1);
        address = 8'd9; // second strobe while busy
        data_in = ~regs[9];
        @(posedge clk);
        #10;
        cs = 1'b0;
        wr = 1'b0;
        drain_busy();
        regs[6] = 8'h3c;
        read_reg(8'd6, d);
        check_value("data_out", 32'(d), 32'h3c);
        read_reg(8'd9, d);
        check_value("data_out", 32'(d), 32'(regs[9]));
        end_test("register access");
    endtask

    task automatic one_voice_left();
        logic [31:0] rnd;
        int          a;
        for (a = 0; a < 32; a++) stage[a] = 8'h00;
        rnd = next_random();
        stage[8]  = rnd[7:0];
        stage[9]  = rnd[15:8] | 8'h10;  // MSB flips within a few frames
        stage[10] = rnd[23:16] | 8'h40;
        stage[11] = 8'h03;              // key-on, left only
        load_regs();
        expect_frames(12);
        end_test("single voice left");
    endtask

    task automatic random_voice_mix();
        random_voices();
        load_regs();
        expect_frames(20);
        end_test("random voice mix");
    endtask

    task automatic mix_clamping();
        int ch;
        for (ch = 0; ch < `OPL_NUM_CHANNELS; ch++) begin
            stage[4*ch]   = 8'h00;
            stage[4*ch+1] = 8'h20;
            stage[4*ch+2] = 8'hff;
            stage[4*ch+3] = 8'h07;
        end
        load_regs();
        expect_frames(10);
        end_test("mix clamping");
    endtask

    task automatic reads_during_playback();
        logic [31:0] rnd;
        logic [7:0]  a;
        logic [7:0]  d;
        int          reads;
        random_voices();
        load_regs();
        playback_done = 1'b0;
        reads = 0;
        fork
            begin
                expect_frames(12);
                playback_done = 1'b1;
            end
            begin
                while (!playback_done && reads < 2000) begin
                    rnd = next_random();
                    a = 8'(rnd[5:0]); // half the addresses out of range
                    read_reg(a, d);
                    check_value("data_out", 32'(d), (a < 8'd32) ? 32'(regs[a[4:0]]) : 32'd0);
                    reads++;
                end
            end
        join
        end_test("reads during playback");
    endtask

    initial begin
        rand_state = 32'hcc77_52a7;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        bit_idx = 0;
        frame_bits = 32'h0;
        playback_done = 1'b0;
        for (int a = 0; a < 32; a++) regs[a] = 8'h00;
        reset = 1'b1;
        cs = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        address = 8'h00;
        data_in = 8'h00;
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;
        verify_reset_state();
        register_access();
        one_voice_left();
        random_voice_mix();
        mix_clamping();
        reads_during_playback();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verilog
verilog/opl_reg_pkg.sv
verilog/opl_audio_pkg.sv
verilog/reg_ram_if.sv
verilog/sample_clk_div.sv
verilog/reg_ram_arbiter.sv
verilog/host_reg_port.sv
verilog/voice_sequencer.sv
verilog/serial_audio_tx.sv
verilog/opl_top.sv
verif/opl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module opl_tb -f compile.f -o opl_sim || exit 1
out=$(./obj_dir/opl_sim)
echo "$out"
echo "$out" | grep -q "^No errors$" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
